// File: source/lsu_pkg.sv
// lsu package: widths, encodings and payload structs for the load/store unit and its bus
package lsu_pkg;

  parameter int ADDR_W = 64;
  parameter int DATA_W = 64;

  // ==================================================
  // encodings
  // ==================================================

  typedef enum logic {
    MEM_LOAD  = 1'b0,
    MEM_STORE = 1'b1
  } mem_op_e;

  typedef enum logic [1:0] {
    WID_B = 2'd0,
    WID_H = 2'd1,
    WID_W = 2'd2,
    WID_D = 2'd3
  } mem_width_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  // controller FSM
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_AR,
    ST_R,
    ST_AW,
    ST_W,
    ST_B
  } lsu_state_e;

  // ==================================================
  // core side
  // ==================================================

  typedef struct packed {
    mem_op_e           op;
    mem_width_e        width;
    logic              is_unsigned;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [4:0]        rd;
  } lsu_req_t;

  typedef struct packed {
    mem_op_e           op;
    logic [4:0]        rd;
    logic [DATA_W-1:0] rdata;
    logic              error;
  } lsu_rsp_t;

  // ==================================================
  // bus channels
  // ==================================================

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } axi_addr_t;

  typedef struct packed {
    logic [DATA_W-1:0]   data;
    logic [DATA_W/8-1:0] strb;
  } axi_wdata_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    axi_resp_e         resp;
  } axi_rdata_t;

endpackage

// File: source/lsu_store_lane.sv
// store lane steering: byte strobe and lane-aligned write data for one store beat
`timescale 1ns/1ps

module lsu_store_lane import lsu_pkg::*; (
  input  mem_width_e          width_i,
  input  logic [2:0]          addr_lo_i,
  input  logic [DATA_W-1:0]   wdata_i,
  output logic [DATA_W/8-1:0] strb_o,
  output logic [DATA_W-1:0]   wdata_o
);

  logic [DATA_W/8-1:0] strb_base;

  // ones for the access size, before the lane shift
  always_comb begin
    case (width_i)
      WID_B:   strb_base = 8'b0000_0001;
      WID_H:   strb_base = 8'b0000_0011;
      WID_W:   strb_base = 8'b0000_1111;
      default: strb_base = 8'b1111_1111;
    endcase
  end

  assign strb_o = strb_base << addr_lo_i;

  // upper bytes pushed out of the beat are masked by the strobe anyway
  assign wdata_o = wdata_i << {addr_lo_i, 3'b000};

endmodule

// File: source/lsu_load_extract.sv
// load extraction: picks the addressed bytes out of a read beat and extends them to 64 bits
`timescale 1ns/1ps

module lsu_load_extract import lsu_pkg::*; (
  input  mem_width_e        width_i,
  input  logic              unsigned_i,
  input  logic [2:0]        addr_lo_i,
  input  logic [DATA_W-1:0] rdata_i,
  output logic [DATA_W-1:0] data_o
);

  logic [DATA_W-1:0] shifted;
  logic              fill;

  // addressed byte moves down to lane 0
  assign shifted = rdata_i >> {addr_lo_i, 3'b000};

  always_comb begin
    case (width_i)
      WID_B: begin
        fill   = shifted[7] & ~unsigned_i;
        data_o = {{56{fill}}, shifted[7:0]};
      end
      WID_H: begin
        fill   = shifted[15] & ~unsigned_i;
        data_o = {{48{fill}}, shifted[15:0]};
      end
      WID_W: begin
        fill   = shifted[31] & ~unsigned_i;
        data_o = {{32{fill}}, shifted[31:0]};
      end
      default: begin
        // full double, nothing to extend
        fill   = 1'b0;
        data_o = shifted;
      end
    endcase
  end

endmodule

// File: source/lsu_ctrl.sv
// load/store controller: accepts core requests, checks alignment and runs the AR/R and AW/W/B channels
`timescale 1ns/1ps

module lsu_ctrl import lsu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  lsu_req_t   req_i,
  output logic       rsp_valid_o,
  output lsu_rsp_t   rsp_o,
  output logic       ar_valid_o,
  input  logic       ar_ready_i,
  output axi_addr_t  ar_o,
  input  logic       r_valid_i,
  output logic       r_ready_o,
  input  axi_rdata_t r_i,
  output logic       aw_valid_o,
  input  logic       aw_ready_i,
  output axi_addr_t  aw_o,
  output logic       w_valid_o,
  input  logic       w_ready_i,
  output axi_wdata_t w_o,
  input  logic       b_valid_i,
  output logic       b_ready_o,
  input  axi_resp_e  b_i
);

  lsu_state_e        state_q;
  lsu_req_t          req_q;
  logic              misal_q;
  logic              w_done_q;
  logic              accept;
  logic              aligned;
  logic              aw_hs;
  logic              w_hs;
  logic [DATA_W-1:0] ld_data;

  // ==================================================
  // request acceptance and alignment
  // ==================================================

  // hold off while a misaligned request is being reported
  assign req_ready_o = (state_q == ST_IDLE) && !misal_q;
  assign accept      = req_valid_i && req_ready_o;

  always_comb begin
    case (req_i.width)
      WID_B:   aligned = 1'b1;
      WID_H:   aligned = (req_i.addr[0] == 1'b0);
      WID_W:   aligned = (req_i.addr[1:0] == 2'b00);
      default: aligned = (req_i.addr[2:0] == 3'b000);
    endcase
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

  // ==================================================
  // channel FSM
  // ==================================================

  assign aw_hs = aw_valid_o && aw_ready_i;
  assign w_hs  = w_valid_o && w_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= ST_IDLE;
      misal_q  <= 1'b0;
      w_done_q <= 1'b0;
    end else begin
      misal_q <= accept && !aligned;
      case (state_q)
        ST_IDLE: begin
          w_done_q <= 1'b0;
          if (accept && aligned) begin
            state_q <= (req_i.op == MEM_LOAD) ? ST_AR : ST_AW;
          end
        end
        ST_AR: if (ar_ready_i) state_q <= ST_R;
        ST_R:  if (r_valid_i) state_q <= ST_IDLE;
        // AW pending, W may or may not have gone already
        ST_AW: begin
          if (w_hs) begin
            w_done_q <= 1'b1;
          end
          if (aw_hs) begin
            state_q <= (w_done_q || w_hs) ? ST_B : ST_W;
          end
        end
        ST_W: if (w_ready_i) state_q <= ST_B;
        ST_B: if (b_valid_i) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign ar_valid_o = (state_q == ST_AR);
  assign r_ready_o  = (state_q == ST_R);
  assign aw_valid_o = (state_q == ST_AW);
  assign w_valid_o  = ((state_q == ST_AW) && !w_done_q) || (state_q == ST_W);
  assign b_ready_o  = (state_q == ST_B);

  assign ar_o.addr = req_q.addr;
  assign aw_o.addr = req_q.addr;

  lsu_store_lane store_lane_i (
    .width_i   (req_q.width),
    .addr_lo_i (req_q.addr[2:0]),
    .wdata_i   (req_q.wdata),
    .strb_o    (w_o.strb),
    .wdata_o   (w_o.data)
  );

  // ==================================================
  // completion
  // ==================================================

  lsu_load_extract load_extract_i (
    .width_i    (req_q.width),
    .unsigned_i (req_q.is_unsigned),
    .addr_lo_i  (req_q.addr[2:0]),
    .rdata_i    (r_i.data),
    .data_o     (ld_data)
  );

  assign rsp_valid_o = misal_q || (r_valid_i && r_ready_o) || (b_valid_i && b_ready_o);

  assign rsp_o.op    = req_q.op;
  assign rsp_o.rd    = req_q.rd;
  assign rsp_o.rdata = (state_q == ST_R) ? ld_data : '0;
  assign rsp_o.error = misal_q
                     || ((state_q == ST_R) && (r_i.resp == RESP_SLVERR))
                     || ((state_q == ST_B) && (b_i == RESP_SLVERR));

  // single request in flight, so the completion never repeats back to back
  a_rsp_pulse: assert property (@(posedge clk) disable iff (rst)
    rsp_valid_o |=> !rsp_valid_o);

  a_no_rd_wr_overlap: assert property (@(posedge clk) disable iff (rst)
    !(ar_valid_o && aw_valid_o));

  a_ar_stable: assert property (@(posedge clk) disable iff (rst)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o));

endmodule

// File: source/axi_mem_model.sv
// single-beat AXI-style memory slave with response latency, byte strobes and range errors
`timescale 1ns/1ps

module axi_mem_model import lsu_pkg::*; #(
  parameter int MEM_WORDS   = 64,
  parameter int MEM_LATENCY = 2
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       ar_valid_i,
  output logic       ar_ready_o,
  input  axi_addr_t  ar_i,
  output logic       r_valid_o,
  input  logic       r_ready_i,
  output axi_rdata_t r_o,
  input  logic       aw_valid_i,
  output logic       aw_ready_o,
  input  axi_addr_t  aw_i,
  input  logic       w_valid_i,
  output logic       w_ready_o,
  input  axi_wdata_t w_i,
  output logic       b_valid_o,
  input  logic       b_ready_i,
  output axi_resp_e  b_o
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int CNT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;
  localparam logic [ADDR_W-1:0] MEM_BYTES = ADDR_W'(MEM_WORDS * 8);

  typedef enum logic [1:0] {
    MS_IDLE,
    MS_WAIT,
    MS_RESP
  } mem_state_e;

  logic [DATA_W-1:0] mem_q [MEM_WORDS];
  mem_state_e        state_q;
  logic [CNT_W-1:0]  cnt_q;
  logic              is_wr_q;
  logic              rd_hs;
  logic              wr_hs;
  logic              ar_in_range;
  logic              aw_in_range;
  logic [IDX_W-1:0]  ar_idx;
  logic [IDX_W-1:0]  aw_idx;

  // ==================================================
  // request side
  // ==================================================

  // AW and W are taken in the same cycle, reads win if both show up
  assign ar_ready_o = (state_q == MS_IDLE);
  assign aw_ready_o = (state_q == MS_IDLE) && !ar_valid_i && w_valid_i;
  assign w_ready_o  = (state_q == MS_IDLE) && !ar_valid_i && aw_valid_i;

  assign rd_hs = ar_valid_i && ar_ready_o;
  assign wr_hs = aw_valid_i && aw_ready_o;

  assign ar_in_range = ar_i.addr < MEM_BYTES;
  assign aw_in_range = aw_i.addr < MEM_BYTES;
  assign ar_idx      = ar_i.addr[IDX_W+2:3];
  assign aw_idx      = aw_i.addr[IDX_W+2:3];

  // latency counter only runs in MS_WAIT
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= MS_IDLE;
      cnt_q   <= '0;
      is_wr_q <= 1'b0;
    end else begin
      case (state_q)
        MS_IDLE: begin
          cnt_q <= '0;
          if (rd_hs || wr_hs) begin
            is_wr_q <= wr_hs;
            state_q <= (MEM_LATENCY == 0) ? MS_RESP : MS_WAIT;
          end
        end
        MS_WAIT: begin
          if (cnt_q == CNT_W'(MEM_LATENCY - 1)) begin
            state_q <= MS_RESP;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        MS_RESP: begin
          if ((r_valid_o && r_ready_i) || (b_valid_o && b_ready_i)) begin
            state_q <= MS_IDLE;
          end
        end
        default: state_q <= MS_IDLE;
      endcase
    end
  end

  // ==================================================
  // storage
  // ==================================================

  // contents start out zero, byte lanes written under strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_hs && aw_in_range) begin
      for (int b = 0; b < DATA_W / 8; b++) begin
        if (w_i.strb[b]) begin
          mem_q[aw_idx][b*8 +: 8] <= w_i.data[b*8 +: 8];
        end
      end
    end
  end

  // response payloads captured at the handshake
  always_ff @(posedge clk) begin
    if (rd_hs) begin
      r_o.data <= ar_in_range ? mem_q[ar_idx] : '0;
      r_o.resp <= ar_in_range ? RESP_OKAY : RESP_SLVERR;
    end
    if (wr_hs) begin
      b_o <= aw_in_range ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign r_valid_o = (state_q == MS_RESP) && !is_wr_q;
  assign b_valid_o = (state_q == MS_RESP) && is_wr_q;

  // the controller raises address and data together for every store
  a_aw_with_w: assert property (@(posedge clk) disable iff (rst)
    $rose(aw_valid_i) |-> w_valid_i);

endmodule

// File: source/lsu_subsys_top.sv
// load/store subsystem top: controller wired to the memory model over the internal bus
`timescale 1ns/1ps

module lsu_subsys_top import lsu_pkg::*; #(
  parameter int MEM_WORDS   = 64,
  parameter int MEM_LATENCY = 2
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  lsu_req_t req_i,
  output logic     rsp_valid_o,
  output lsu_rsp_t rsp_o
);

  // read channels
  logic       ar_valid;
  logic       ar_ready;
  axi_addr_t  ar;
  logic       r_valid;
  logic       r_ready;
  axi_rdata_t r;

  // write channels
  logic       aw_valid;
  logic       aw_ready;
  axi_addr_t  aw;
  logic       w_valid;
  logic       w_ready;
  axi_wdata_t w;
  logic       b_valid;
  logic       b_ready;
  axi_resp_e  b;

  lsu_ctrl ctrl_i (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o),
    .ar_valid_o  (ar_valid),
    .ar_ready_i  (ar_ready),
    .ar_o        (ar),
    .r_valid_i   (r_valid),
    .r_ready_o   (r_ready),
    .r_i         (r),
    .aw_valid_o  (aw_valid),
    .aw_ready_i  (aw_ready),
    .aw_o        (aw),
    .w_valid_o   (w_valid),
    .w_ready_i   (w_ready),
    .w_o         (w),
    .b_valid_i   (b_valid),
    .b_ready_o   (b_ready),
    .b_i         (b)
  );

  axi_mem_model #(
    .MEM_WORDS   (MEM_WORDS),
    .MEM_LATENCY (MEM_LATENCY)
  ) mem_i (
    .clk        (clk),
    .rst        (rst),
    .ar_valid_i (ar_valid),
    .ar_ready_o (ar_ready),
    .ar_i       (ar),
    .r_valid_o  (r_valid),
    .r_ready_i  (r_ready),
    .r_o        (r),
    .aw_valid_i (aw_valid),
    .aw_ready_o (aw_ready),
    .aw_i       (aw),
    .w_valid_i  (w_valid),
    .w_ready_o  (w_ready),
    .w_i        (w),
    .b_valid_o  (b_valid),
    .b_ready_i  (b_ready),
    .b_o        (b)
  );

endmodule

// File: test/lsu_checker.sv
// lsu checker: keeps a byte image of memory and checks every completion against it
`timescale 1ns/1ps

module lsu_checker import lsu_pkg::*; #(
  parameter int MEM_WORDS = 64,
  parameter int NAME_LEN  = 16
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req_valid_i,
  input  logic                  req_ready_i,
  input  lsu_req_t              req_i,
  input  logic                  rsp_valid_i,
  input  lsu_rsp_t              rsp_i,
  input  logic [8*NAME_LEN-1:0] name_i,
  input  logic                  exp_err_i,
  output int                    pass_cnt_o,
  output int                    fail_cnt_o
);

  logic [7:0]            img [MEM_WORDS*8];
  logic                  busy;
  logic                  bad;
  lsu_rsp_t              exp_q;
  string                 name_q;

  // packed name to text, leading null bytes dropped
  function automatic string name_text(input logic [8*NAME_LEN-1:0] v);
    string s;
    s = "";
    for (int k = NAME_LEN - 1; k >= 0; k--) begin
      if (v[8*k +: 8] != 8'h00) begin
        s = $sformatf("%s%c", s, v[8*k +: 8]);
      end
    end
    return s;
  endfunction

  // ==================================================
  // reference model
  // ==================================================

  // aligned means the address is a multiple of the access size
  task automatic apply_request(input lsu_req_t req, output lsu_rsp_t exp);
    int                nbytes;
    logic              misaligned;
    logic              out_of_range;
    logic [DATA_W-1:0] val;
    nbytes       = 1 << req.width;
    misaligned   = (req.addr % nbytes) != 0;
    out_of_range = req.addr >= MEM_WORDS * 8;
    val          = '0;
    exp.op       = req.op;
    exp.rd       = req.rd;
    exp.error    = misaligned || out_of_range;
    exp.rdata    = '0;
    if (!exp.error) begin
      for (int k = 0; k < nbytes; k++) begin
        if (req.op == MEM_STORE) begin
          img[req.addr + k] = req.wdata[8*k +: 8];
        end else begin
          val[8*k +: 8] = img[req.addr + k];
        end
      end
      if (req.op == MEM_LOAD) begin
        // sign fill from the top loaded bit
        if (!req.is_unsigned && val[8*nbytes-1]) begin
          for (int k = 8 * nbytes; k < DATA_W; k++) begin
            val[k] = 1'b1;
          end
        end
        exp.rdata = val;
      end
    end
  endtask

  task automatic compare_value(input string field, input logic [63:0] expv,
                               input logic [63:0] actv);
    if (expv !== actv) begin
      $display("** Error %s: %s expected %h actual %h", name_q, field, expv, actv);
      bad = 1'b1;
    end
  endtask

  // ==================================================
  // monitor
  // ==================================================

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < MEM_WORDS * 8; i++) begin
        img[i] = 8'h00;
      end
      busy       = 1'b0;
      bad        = 1'b0;
      pass_cnt_o = 0;
      fail_cnt_o = 0;
    end else begin
      if (rsp_valid_i) begin
        if (!busy) begin
          $display("response arrived with no request outstanding at %0t", $time);
          fail_cnt_o++;
        end else begin
          compare_value("op", exp_q.op, rsp_i.op);
          compare_value("rd", exp_q.rd, rsp_i.rd);
          compare_value("error", exp_q.error, rsp_i.error);
          if (exp_q.op == MEM_LOAD) begin
            compare_value("rdata", exp_q.rdata, rsp_i.rdata);
          end
          if (bad) begin
            $display("test %s failed", name_q);
            fail_cnt_o++;
          end else begin
            $display("test %s passed", name_q);
            pass_cnt_o++;
          end
          busy = 1'b0;
        end
      end else if (busy && req_ready_i) begin
        $display("%s: request ready went high before the response", name_q);
        bad = 1'b1;
      end
      if (req_valid_i && req_ready_i) begin
        name_q = name_text(name_i);
        bad    = 1'b0;
        apply_request(req_i, exp_q);
        // table error flag must agree with the reference model
        if (exp_err_i !== exp_q.error) begin
          $display("%s: table error flag %0b disagrees with the reference model", name_q,
                   exp_err_i);
          bad = 1'b1;
        end
        busy = 1'b1;
      end
    end
  end

endmodule

// File: test/lsu_tb.sv
// load/store subsystem testbench: clock, reset, request table, driver loop and watchdog
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

  localparam int MEM_WORDS   = 64;
  localparam int MEM_LATENCY = 2;
  localparam int NAME_LEN    = 16;
  localparam int CLK_PERIOD  = 10;

  typedef struct packed {
    logic [8*NAME_LEN-1:0] name;
    lsu_req_t              req;
    logic                  exp_err;
  } test_entry_t;

  test_entry_t           tbl [$];
  integer                seed;
  bit                    table_built;
  logic                  clk;
  logic                  rst;
  logic                  req_valid;
  logic                  req_ready;
  lsu_req_t              req;
  logic                  rsp_valid;
  lsu_rsp_t              rsp;
  logic [8*NAME_LEN-1:0] cur_name;
  logic                  cur_exp_err;
  int                    pass_cnt;
  int                    fail_cnt;

  lsu_subsys_top #(
    .MEM_WORDS   (MEM_WORDS),
    .MEM_LATENCY (MEM_LATENCY)
  ) dut_i (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .req_i       (req),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp)
  );

  lsu_checker #(
    .MEM_WORDS (MEM_WORDS),
    .NAME_LEN  (NAME_LEN)
  ) checker_i (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (req_valid),
    .req_ready_i (req_ready),
    .req_i       (req),
    .rsp_valid_i (rsp_valid),
    .rsp_i       (rsp),
    .name_i      (cur_name),
    .exp_err_i   (cur_exp_err),
    .pass_cnt_o  (pass_cnt),
    .fail_cnt_o  (fail_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic add_test(input logic [8*NAME_LEN-1:0] name, input mem_op_e op,
                          input mem_width_e width, input logic uns, input logic [63:0] addr,
                          input logic [63:0] wdata, input logic [4:0] rd, input logic err);
    test_entry_t e;
    e.name            = name;
    e.req.op          = op;
    e.req.width       = width;
    e.req.is_unsigned = uns;
    e.req.addr        = addr;
    e.req.wdata       = wdata;
    e.req.rd          = rd;
    e.exp_err         = err;
    tbl.push_back(e);
  endtask

  // ==================================================
  // stimulus table
  // ==================================================

  task automatic build_table();
    // double round trip
    add_test("st_d_10", MEM_STORE, WID_D, 0, 'h10, rand64(), 5'd0, 0);
    add_test("ld_d_10", MEM_LOAD, WID_D, 0, 'h10, 0, 5'd1, 0);
    // partial stores merged into one word
    add_test("st_d_20", MEM_STORE, WID_D, 0, 'h20, 64'h1122_3344_5566_7788, 5'd0, 0);
    add_test("st_b_21", MEM_STORE, WID_B, 0, 'h21, rand64(), 5'd0, 0);
    add_test("st_h_22", MEM_STORE, WID_H, 0, 'h22, rand64(), 5'd0, 0);
    add_test("st_w_24", MEM_STORE, WID_W, 0, 'h24, 64'hdead_beef_0bad_f00d, 5'd0, 0);
    add_test("ld_d_20", MEM_LOAD, WID_D, 0, 'h20, 0, 5'd2, 0);
    // every byte of this word has its top bit set
    add_test("st_d_30", MEM_STORE, WID_D, 0, 'h30, 64'hf1e2_d3c4_b5a6_9788, 5'd0, 0);
    add_test("lb_30", MEM_LOAD, WID_B, 0, 'h30, 0, 5'd3, 0);
    add_test("lb_31", MEM_LOAD, WID_B, 0, 'h31, 0, 5'd4, 0);
    add_test("lbu_31", MEM_LOAD, WID_B, 1, 'h31, 0, 5'd5, 0);
    add_test("lh_32", MEM_LOAD, WID_H, 0, 'h32, 0, 5'd6, 0);
    add_test("lhu_32", MEM_LOAD, WID_H, 1, 'h32, 0, 5'd7, 0);
    add_test("lw_34", MEM_LOAD, WID_W, 0, 'h34, 0, 5'd8, 0);
    add_test("lwu_34", MEM_LOAD, WID_W, 1, 'h34, 0, 5'd9, 0);
    // misaligned requests, memory at 0x40 must stay zero
    add_test("st_h_41", MEM_STORE, WID_H, 0, 'h41, rand64(), 5'd0, 1);
    add_test("st_w_42", MEM_STORE, WID_W, 0, 'h42, rand64(), 5'd0, 1);
    add_test("st_d_44", MEM_STORE, WID_D, 0, 'h44, rand64(), 5'd0, 1);
    add_test("lh_33", MEM_LOAD, WID_H, 0, 'h33, 0, 5'd10, 1);
    add_test("lw_36", MEM_LOAD, WID_W, 0, 'h36, 0, 5'd11, 1);
    add_test("ld_d_34", MEM_LOAD, WID_D, 0, 'h34, 0, 5'd12, 1);
    add_test("ld_d_40", MEM_LOAD, WID_D, 0, 'h40, 0, 5'd13, 0);
    // range edge and beyond
    add_test("ld_d_200", MEM_LOAD, WID_D, 0, 'h200, 0, 5'd14, 1);
    // low address bits of 0x230 land on the non-zero word at 0x30
    add_test("ld_d_230", MEM_LOAD, WID_D, 0, 'h230, 0, 5'd16, 1);
    add_test("st_d_208", MEM_STORE, WID_D, 0, 'h208, rand64(), 5'd0, 1);
    // word at 0x08 shares its index bits with 0x208
    add_test("ld_d_08", MEM_LOAD, WID_D, 0, 'h08, 0, 5'd17, 0);
    add_test("lbu_3ff", MEM_LOAD, WID_B, 1, 'h3ff, 0, 5'd15, 1);
    add_test("st_w_1fc", MEM_STORE, WID_W, 0, 'h1fc, rand64(), 5'd0, 0);
    add_test("lw_1fc", MEM_LOAD, WID_W, 0, 'h1fc, 0, 5'd30, 0);
    add_test("ld_d_1f8", MEM_LOAD, WID_D, 0, 'h1f8, 0, 5'd31, 0);
  endtask

  // ==================================================
  // driver
  // ==================================================

  initial begin
    seed        = 32'hef4e85e3;
    rst         = 1'b1;
    req_valid   = 1'b0;
    req         = '0;
    cur_name    = '0;
    cur_exp_err = 1'b0;
    build_table();
    table_built = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < tbl.size(); i++) begin
      @(negedge clk);
      cur_name    = tbl[i].name;
      cur_exp_err = tbl[i].exp_err;
      req         = tbl[i].req;
      req_valid   = 1'b1;
      do @(posedge clk); while (!req_ready);
      @(negedge clk);
      req_valid = 1'b0;
      do @(posedge clk); while (!rsp_valid);
    end
    // let the checker finish with the last response
    @(negedge clk);
    $display("tests run %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt == tbl.size()) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // budget of latency plus ten cycles per entry, plus reset
  initial begin
    wait (table_built);
    #((tbl.size() * (MEM_LATENCY + 10) + 8) * CLK_PERIOD);
    $display("timeout: a request got no response in time, run stopped at %0t", $time);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: sim.f
source/lsu_pkg.sv
source/lsu_store_lane.sv
source/lsu_load_extract.sv
source/lsu_ctrl.sv
source/axi_mem_model.sv
source/lsu_subsys_top.sv
test/lsu_checker.sv
test/lsu_tb.sv
